//--- source/obi_mem_defines.svh
// OBI memory wrapper defines
// Bus widths, RAM size and the virtual-peripheral address map shared
// by the package and the RTL blocks

`ifndef OBI_MEM_DEFINES_SVH
`define OBI_MEM_DEFINES_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define OBI_ADDR_W 32
`define OBI_DATA_W 32
// One enable per byte lane of the data bus
`define OBI_BE_W 4

// ----------------------------------------------------------------------
// RAM geometry
// ----------------------------------------------------------------------
// Word address width, 1024 words of 32 bits at byte address 0
`define RAM_ADDR_W 10
`define RAM_DEPTH (1 << `RAM_ADDR_W)

// ----------------------------------------------------------------------
// Virtual peripherals
// ----------------------------------------------------------------------
`define VP_BASE 32'h1000_0000
// Write-only character sink
`define VP_STDOUT_ADDR (`VP_BASE)
// Test-exit status, readable
`define VP_EXIT_ADDR (`VP_BASE + 32'h4)

`endif

//--- source/obi_mem_pkg.sv
// OBI memory wrapper types
// Request and response structs for the instruction and data ports,
// plus the bundle of virtual-peripheral outputs

`include "obi_mem_defines.svh"

package obi_mem_pkg;

    // ------------------------------------------------------------------
    // Requests
    // ------------------------------------------------------------------

    // Instruction fetch, always a full word read
    typedef struct packed {
        logic [`OBI_ADDR_W-1:0] addr;
    } obi_instr_req_t;

    // Data access with write enable and byte lanes
    typedef struct packed {
        logic [`OBI_ADDR_W-1:0] addr;
        logic                   we;
        logic [`OBI_BE_W-1:0]   be;
        logic [`OBI_DATA_W-1:0] wdata;
    } obi_data_req_t;

    // ------------------------------------------------------------------
    // Responses
    // ------------------------------------------------------------------

    // Same response shape on both ports
    typedef struct packed {
        logic [`OBI_DATA_W-1:0] rdata;
        logic                   err;
    } obi_rsp_t;

    // ------------------------------------------------------------------
    // Virtual peripherals
    // ------------------------------------------------------------------

    // Stdout strobe and sticky test-exit status
    typedef struct packed {
        logic                   stdout_valid;
        logic [7:0]             stdout_char;
        logic                   exit_valid;
        logic [`OBI_DATA_W-1:0] exit_code;
    } vp_out_t;

endpackage

//--- source/obi_port_ctrl.sv
// OBI port responder
// Grants every request, issues the accepted request downstream one
// cycle later and returns the target response with rvalid
// Also checks the request parity line and keeps a sticky alert

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module obi_port_ctrl #(
    parameter type REQ_T = obi_mem_pkg::obi_data_req_t
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 req_i,
    input  logic                 reqpar_i,
    input  REQ_T                 req_payload_i,
    output logic                 gnt_o,
    output logic                 rvalid_o,
    output obi_mem_pkg::obi_rsp_t rsp_o,
    output logic                 issue_o,
    output REQ_T                 issue_payload_o,
    input  obi_mem_pkg::obi_rsp_t issue_rsp_i,
    output logic                 alert_o
);

    import obi_mem_pkg::*;

    logic     accept;
    logic     issue_q;
    REQ_T     payload_q;
    obi_rsp_t rsp_q;
    logic     parity_bad;
    logic     alert_q;

    // ------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------

    // No wait states, the port never stalls
    assign gnt_o  = req_i;
    assign accept = req_i && gnt_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= accept;
        end
    end

    // Payload only moves on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            payload_q <= req_payload_i;
        end
    end

    assign issue_o         = issue_q;
    assign issue_payload_o = payload_q;

    // ------------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------------

    // rready is tied high, so the response goes out in the issue cycle
    assign rvalid_o = issue_q;

    // Keep the last response on the bus between transfers
    always_ff @(posedge clk_i) begin
        if (issue_q) begin
            rsp_q <= issue_rsp_i;
        end
    end

    assign rsp_o = issue_q ? issue_rsp_i : rsp_q;

    // ------------------------------------------------------------------
    // Request parity
    // ------------------------------------------------------------------

    // reqpar must be the inverse of req in every cycle
    assign parity_bad = (reqpar_i == req_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alert_q <= 1'b0;
        end else begin
            alert_q <= alert_q | parity_bad;
        end
    end

    assign alert_o = alert_q;

    // Each response pairs with a handshake one cycle earlier
    a_rvalid_after_accept: assert property (
        @(posedge clk_i) disable iff (reset_i)
        rvalid_o |-> $past(req_i && gnt_o)
    );

    // Grant must never run ahead of the core
    a_gnt_needs_req: assert property (
        @(posedge clk_i) disable iff (reset_i)
        gnt_o |-> req_i
    );

endmodule

//--- source/obi_ram.sv
// Dual-port word RAM
// Asynchronous read on the instruction and data ports, byte-lane
// writes on the data port at the clock edge

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module obi_ram (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   i_en_i,
    input  logic [`OBI_ADDR_W-1:0] i_addr_i,
    output logic [`OBI_DATA_W-1:0] i_rdata_o,
    input  logic                   d_en_i,
    input  logic                   d_we_i,
    input  logic [`OBI_BE_W-1:0]   d_be_i,
    input  logic [`OBI_ADDR_W-1:0] d_addr_i,
    input  logic [`OBI_DATA_W-1:0] d_wdata_i,
    output logic [`OBI_DATA_W-1:0] d_rdata_o
);

    logic [`OBI_DATA_W-1:0] mem [`RAM_DEPTH];
    logic [`RAM_ADDR_W-1:0] i_idx;
    logic [`RAM_ADDR_W-1:0] d_idx;

    // Word index from byte address, upper bits already decoded
    assign i_idx = i_addr_i[`RAM_ADDR_W+1:2];
    assign d_idx = d_addr_i[`RAM_ADDR_W+1:2];

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    // Cleared on reset so every read returns known data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < `RAM_DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (d_en_i && d_we_i) begin
            for (int b = 0; b < `OBI_BE_W; b++) begin
                if (d_be_i[b]) begin
                    mem[d_idx][8*b +: 8] <= d_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Reads see the contents before a write on the same edge
    assign i_rdata_o = i_en_i ? mem[i_idx] : '0;
    assign d_rdata_o = d_en_i ? mem[d_idx] : '0;

    // A data write must touch at least one byte lane
    a_write_has_be: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (d_en_i && d_we_i) |-> (d_be_i != '0)
    );

endmodule

//--- source/obi_data_router.sv
// Data-port address decoder
// Steers an issued data access to the RAM or the virtual peripherals,
// and answers anything else with an error

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module obi_data_router (
    input  logic                       issue_i,
    input  obi_mem_pkg::obi_data_req_t req_i,
    output obi_mem_pkg::obi_rsp_t      rsp_o,
    output logic                       d_en_o,
    output logic                       d_we_o,
    output logic [`OBI_BE_W-1:0]       d_be_o,
    output logic [`OBI_ADDR_W-1:0]     d_addr_o,
    output logic [`OBI_DATA_W-1:0]     d_wdata_o,
    input  logic [`OBI_DATA_W-1:0]     d_rdata_i,
    output logic                       vp_sel_o,
    input  logic [`OBI_DATA_W-1:0]     vp_rdata_i
);

    import obi_mem_pkg::*;

    logic ram_hit;
    logic vp_hit;

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------

    // RAM covers the first 4 KiB
    assign ram_hit = (req_i.addr[`OBI_ADDR_W-1:`RAM_ADDR_W+2] == '0);

    // Only the two peripheral registers respond in the window
    assign vp_hit = (req_i.addr == `VP_STDOUT_ADDR) ||
                    (req_i.addr == `VP_EXIT_ADDR);

    // ------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------

    // RAM data port
    assign d_en_o    = issue_i && ram_hit;
    assign d_we_o    = req_i.we;
    assign d_be_o    = req_i.be;
    assign d_addr_o  = req_i.addr;
    assign d_wdata_o = req_i.wdata;

    // Peripheral select
    assign vp_sel_o = issue_i && vp_hit;

    // ------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------

    always_comb begin
        rsp_o = '0;
        if (ram_hit) begin
            rsp_o.rdata = d_rdata_i;
        end else if (vp_hit) begin
            // Both window registers read back the exit code
            rsp_o.rdata = vp_rdata_i;
        end else begin
            // Unmapped, rdata stays zero
            rsp_o.err = 1'b1;
        end
    end

endmodule

//--- source/vp_status.sv
// Virtual peripherals
// Stdout character strobe and sticky test-exit status, written
// through the data port window

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module vp_status (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       sel_i,
    input  obi_mem_pkg::obi_data_req_t req_i,
    output logic [`OBI_DATA_W-1:0]     rdata_o,
    output obi_mem_pkg::vp_out_t       vp_o
);

    import obi_mem_pkg::*;

    logic                   stdout_hit;
    logic                   exit_hit;
    logic [7:0]             char_q;
    logic                   exit_valid_q;
    logic [`OBI_DATA_W-1:0] exit_code_q;

    // Writes only, reads are answered through rdata_o
    assign stdout_hit = sel_i && req_i.we && (req_i.addr == `VP_STDOUT_ADDR);
    assign exit_hit   = sel_i && req_i.we && (req_i.addr == `VP_EXIT_ADDR);

    // ------------------------------------------------------------------
    // Stdout
    // ------------------------------------------------------------------

    // Last character seen, low byte regardless of byte enables
    always_ff @(posedge clk_i) begin
        if (stdout_hit) begin
            char_q <= req_i.wdata[7:0];
        end
    end

    // ------------------------------------------------------------------
    // Exit status
    // ------------------------------------------------------------------

    // Set once, held until reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exit_valid_q <= 1'b0;
            exit_code_q  <= '0;
        end else if (exit_hit) begin
            exit_valid_q <= 1'b1;
            exit_code_q  <= req_i.wdata;
        end
    end

    assign rdata_o = exit_code_q;

    // Strobe lines up with rvalid of the write
    assign vp_o.stdout_valid = stdout_hit;
    assign vp_o.stdout_char  = stdout_hit ? req_i.wdata[7:0] : char_q;
    assign vp_o.exit_valid   = exit_valid_q;
    assign vp_o.exit_code    = exit_code_q;

    // Exit status only clears through reset
    a_exit_sticky: assert property (
        @(posedge clk_i)
        ($past(exit_valid_q) && !exit_valid_q) |-> $past(reset_i)
    );

endmodule

//--- source/obi_mem_wrap.sv
// OBI memory wrapper
// Serves a core's instruction and data ports from a shared RAM and
// maps the stdout and test-exit peripherals into the data space

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module obi_mem_wrap (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        instr_req_i,
    input  logic                        instr_reqpar_i,
    input  obi_mem_pkg::obi_instr_req_t instr_i,
    output logic                        instr_gnt_o,
    output logic                        instr_rvalid_o,
    output obi_mem_pkg::obi_rsp_t       instr_rsp_o,
    input  logic                        data_req_i,
    input  logic                        data_reqpar_i,
    input  obi_mem_pkg::obi_data_req_t  data_i,
    output logic                        data_gnt_o,
    output logic                        data_rvalid_o,
    output obi_mem_pkg::obi_rsp_t       data_rsp_o,
    output obi_mem_pkg::vp_out_t        vp_o,
    output logic [1:0]                  alert_o
);

    import obi_mem_pkg::*;

    logic                   instr_issue;
    obi_instr_req_t         instr_issue_req;
    obi_rsp_t               instr_issue_rsp;
    logic [`OBI_DATA_W-1:0] instr_rdata;
    logic                   data_issue;
    obi_data_req_t          data_issue_req;
    obi_rsp_t               data_issue_rsp;
    logic                   ram_d_en;
    logic                   ram_d_we;
    logic [`OBI_BE_W-1:0]   ram_d_be;
    logic [`OBI_ADDR_W-1:0] ram_d_addr;
    logic [`OBI_DATA_W-1:0] ram_d_wdata;
    logic [`OBI_DATA_W-1:0] ram_d_rdata;
    logic                   vp_sel;
    logic [`OBI_DATA_W-1:0] vp_rdata;

    // Fetches never fail
    assign instr_issue_rsp = '{rdata: instr_rdata, err: 1'b0};

    // ------------------------------------------------------------------
    // Port controllers
    // ------------------------------------------------------------------
    obi_port_ctrl #(.REQ_T(obi_instr_req_t)) u_instr_port (
        .clk_i(clk_i), .reset_i(reset_i), .req_i(instr_req_i),
        .reqpar_i(instr_reqpar_i), .req_payload_i(instr_i),
        .gnt_o(instr_gnt_o), .rvalid_o(instr_rvalid_o), .rsp_o(instr_rsp_o),
        .issue_o(instr_issue), .issue_payload_o(instr_issue_req),
        .issue_rsp_i(instr_issue_rsp), .alert_o(alert_o[0])
    );

    obi_port_ctrl #(.REQ_T(obi_data_req_t)) u_data_port (
        .clk_i(clk_i), .reset_i(reset_i), .req_i(data_req_i),
        .reqpar_i(data_reqpar_i), .req_payload_i(data_i),
        .gnt_o(data_gnt_o), .rvalid_o(data_rvalid_o), .rsp_o(data_rsp_o),
        .issue_o(data_issue), .issue_payload_o(data_issue_req),
        .issue_rsp_i(data_issue_rsp), .alert_o(alert_o[1])
    );

    // ------------------------------------------------------------------
    // Data decode, storage and peripherals
    // ------------------------------------------------------------------
    obi_data_router u_router (
        .issue_i(data_issue), .req_i(data_issue_req), .rsp_o(data_issue_rsp),
        .d_en_o(ram_d_en), .d_we_o(ram_d_we), .d_be_o(ram_d_be),
        .d_addr_o(ram_d_addr), .d_wdata_o(ram_d_wdata),
        .d_rdata_i(ram_d_rdata), .vp_sel_o(vp_sel), .vp_rdata_i(vp_rdata)
    );

    obi_ram u_ram (
        .clk_i(clk_i), .reset_i(reset_i),
        .i_en_i(instr_issue), .i_addr_i(instr_issue_req.addr),
        .i_rdata_o(instr_rdata),
        .d_en_i(ram_d_en), .d_we_i(ram_d_we), .d_be_i(ram_d_be),
        .d_addr_i(ram_d_addr), .d_wdata_i(ram_d_wdata), .d_rdata_o(ram_d_rdata)
    );

    vp_status u_vp (
        .clk_i(clk_i), .reset_i(reset_i), .sel_i(vp_sel),
        .req_i(data_issue_req), .rdata_o(vp_rdata), .vp_o(vp_o)
    );

endmodule

//--- tests/tb_obi_mem_wrap.sv
// Testbench for the OBI memory wrapper
// Plays the core on both ports, keeps a shadow memory and peripheral
// model, and checks every response with concurrent assertions

`timescale 1ns/1ps

`include "obi_mem_defines.svh"

module tb_obi_mem_wrap;

    import obi_mem_pkg::*;

    localparam int WAIT_LIMIT = 16;

    logic           clk;
    logic           reset;
    logic           instr_req;
    logic           instr_reqpar;
    obi_instr_req_t instr_pl;
    logic           instr_gnt;
    logic           instr_rvalid;
    obi_rsp_t       instr_rsp;
    logic           data_req;
    logic           data_reqpar;
    obi_data_req_t  data_pl;
    logic           data_gnt;
    logic           data_rvalid;
    obi_rsp_t       data_rsp;
    vp_out_t        vp;
    logic [1:0]     alert;
    integer         seed = 54861;

    // Shadow state, updated at acceptance
    logic [`OBI_DATA_W-1:0] shadow [`RAM_DEPTH];
    logic                   model_exit_valid;
    logic [`OBI_DATA_W-1:0] model_exit_code;
    logic [1:0]             model_alert;

    // Expected responses for the cycle after acceptance
    logic                   instr_pend;
    logic                   data_pend;
    logic                   stdout_pend;
    obi_rsp_t               instr_exp;
    obi_rsp_t               data_exp;
    logic [7:0]             stdout_char_exp;
    logic                   exit_valid_exp;
    logic [`OBI_DATA_W-1:0] exit_code_exp;

    obi_mem_wrap i_dut (
        .clk_i(clk), .reset_i(reset),
        .instr_req_i(instr_req), .instr_reqpar_i(instr_reqpar), .instr_i(instr_pl),
        .instr_gnt_o(instr_gnt), .instr_rvalid_o(instr_rvalid), .instr_rsp_o(instr_rsp),
        .data_req_i(data_req), .data_reqpar_i(data_reqpar), .data_i(data_pl),
        .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid), .data_rsp_o(data_rsp),
        .vp_o(vp), .alert_o(alert)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        fail_run($sformatf("mismatch at %0t: %s expected %0h actual %0h",
                           $time, name, exp, act));
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // RAM below 4 KiB, two window registers read the exit code, rest errors
    function automatic obi_rsp_t expect_data(input obi_data_req_t r);
        obi_rsp_t e;
        e = '0;
        if (r.addr < (`RAM_DEPTH * 4)) begin
            e.rdata = shadow[r.addr[`RAM_ADDR_W+1:2]];
        end else if (r.addr == `VP_STDOUT_ADDR || r.addr == `VP_EXIT_ADDR) begin
            e.rdata = model_exit_code;
        end else begin
            e.err = 1'b1;
        end
        return e;
    endfunction

    function automatic void apply_write(input obi_data_req_t r);
        if (r.addr < (`RAM_DEPTH * 4)) begin
            // Same byte-lane rule as the RAM
            for (int b = 0; b < `OBI_BE_W; b++) begin
                if (r.be[b]) begin
                    shadow[r.addr[`RAM_ADDR_W+1:2]][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
        end else if (r.addr == `VP_EXIT_ADDR) begin
            model_exit_valid = 1'b1;
            model_exit_code  = r.wdata;
        end
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `RAM_DEPTH; w++) begin
                shadow[w] = '0;
            end
            model_exit_valid = 1'b0;
            model_exit_code  = '0;
            model_alert      = 2'b00;
            instr_pend     <= 1'b0;
            data_pend      <= 1'b0;
            stdout_pend    <= 1'b0;
            exit_valid_exp <= 1'b0;
            exit_code_exp  <= '0;
        end else begin
            // Exit register lags the accepted write by its issue cycle
            exit_valid_exp <= model_exit_valid;
            exit_code_exp  <= model_exit_code;
            // Sticky alert when reqpar is not the inverse of req
            if (instr_reqpar == instr_req) begin
                model_alert[0] = 1'b1;
            end
            if (data_reqpar == data_req) begin
                model_alert[1] = 1'b1;
            end
            instr_pend  <= instr_req && instr_gnt;
            data_pend   <= data_req && data_gnt;
            stdout_pend <= data_req && data_gnt && data_pl.we &&
                           (data_pl.addr == `VP_STDOUT_ADDR);
            // Fetch in the same cycle as a write sees the old word
            if (instr_req && instr_gnt) begin
                instr_exp <= '{rdata: shadow[instr_pl.addr[`RAM_ADDR_W+1:2]], err: 1'b0};
            end
            if (data_req && data_gnt) begin
                data_exp        <= expect_data(data_pl);
                stdout_char_exp <= data_pl.wdata[7:0];
                if (data_pl.we) begin
                    apply_write(data_pl);
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_instr_gnt: assert property (@(posedge clk) disable iff (reset) instr_gnt == instr_req)
        else report_mismatch("instr_gnt_o", $sampled(instr_req), $sampled(instr_gnt));
    a_data_gnt: assert property (@(posedge clk) disable iff (reset) data_gnt == data_req)
        else report_mismatch("data_gnt_o", $sampled(data_req), $sampled(data_gnt));

    // rvalid exactly one cycle after each acceptance
    a_instr_rvalid: assert property (@(posedge clk) disable iff (reset)
        instr_rvalid == instr_pend)
        else report_mismatch("instr_rvalid_o", $sampled(instr_pend), $sampled(instr_rvalid));
    a_data_rvalid: assert property (@(posedge clk) disable iff (reset)
        data_rvalid == data_pend)
        else report_mismatch("data_rvalid_o", $sampled(data_pend), $sampled(data_rvalid));

    a_instr_rsp: assert property (@(posedge clk) disable iff (reset)
        instr_rvalid |-> instr_rsp == instr_exp)
        else report_mismatch("instr_rsp_o", $sampled(instr_exp), $sampled(instr_rsp));
    a_data_rsp: assert property (@(posedge clk) disable iff (reset)
        data_rvalid |-> data_rsp == data_exp)
        else report_mismatch("data_rsp_o", $sampled(data_exp), $sampled(data_rsp));

    // Stdout strobe rides with the write's rvalid
    a_stdout_valid: assert property (@(posedge clk) disable iff (reset)
        vp.stdout_valid == stdout_pend)
        else report_mismatch("stdout_valid", $sampled(stdout_pend),
                             $sampled(vp.stdout_valid));
    a_stdout_char: assert property (@(posedge clk) disable iff (reset)
        vp.stdout_valid |-> vp.stdout_char == stdout_char_exp)
        else report_mismatch("stdout_char", $sampled(stdout_char_exp),
                             $sampled(vp.stdout_char));

    a_exit_valid: assert property (@(posedge clk) disable iff (reset)
        vp.exit_valid == exit_valid_exp)
        else report_mismatch("exit_valid", $sampled(exit_valid_exp), $sampled(vp.exit_valid));
    a_exit_code: assert property (@(posedge clk) disable iff (reset)
        vp.exit_code == exit_code_exp)
        else report_mismatch("exit_code", $sampled(exit_code_exp), $sampled(vp.exit_code));

    a_alert: assert property (@(posedge clk) disable iff (reset) alert == model_alert)
        else report_mismatch("alert_o", $sampled(model_alert), $sampled(alert));

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------
    function automatic obi_instr_req_t make_fetch(input logic [31:0] a);
        return '{addr: a};
    endfunction

    function automatic obi_data_req_t make_data(input logic [31:0] a, input logic w,
                                                input logic [3:0] b, input logic [31:0] d);
        return '{addr: a, we: w, be: b, wdata: d};
    endfunction

    // One of the first 16 words
    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = $random(seed);
        return {26'd0, r[3:0], 2'b00};
    endfunction

    function automatic logic [3:0] random_be();
        logic [31:0] r;
        logic [3:0]  be;
        r  = $random(seed);
        be = r[3:0];
        if (be == 4'h0) begin
            be = 4'hf;
        end
        return be;
    endfunction

    // Present one cycle of requests, held until granted
    task automatic drive_cycle(input logic i_req, input obi_instr_req_t i_pl,
                               input logic d_req, input obi_data_req_t d_pl,
                               input logic [1:0] bad_par);
        int waited;
        @(posedge clk);
        instr_req    <= i_req;
        instr_reqpar <= ~i_req ^ bad_par[0];
        instr_pl     <= i_pl;
        data_req     <= d_req;
        data_reqpar  <= ~d_req ^ bad_par[1];
        data_pl      <= d_pl;
        waited = 0;
        @(negedge clk);
        while ((i_req && !instr_gnt) || (d_req && !data_gnt)) begin
            if (waited >= WAIT_LIMIT) begin
                fail_run("timeout waiting for gnt");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // Idle both ports and wait for the last rvalid to pass
    task automatic drain_responses();
        int waited;
        drive_cycle(1'b0, make_fetch('0), 1'b0, make_data('0, 1'b0, 4'h0, '0), 2'b00);
        waited = 0;
        while (instr_rvalid || data_rvalid) begin
            if (waited >= WAIT_LIMIT) begin
                fail_run("timeout waiting for rvalid to drop");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_exit();
        int waited;
        waited = 0;
        while (!vp.exit_valid) begin
            if (waited >= WAIT_LIMIT) begin
                fail_run("timeout waiting for exit_valid");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_alert(input int port);
        int waited;
        waited = 0;
        while (!alert[port]) begin
            if (waited >= WAIT_LIMIT) begin
                fail_run("timeout waiting for the parity alert");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]   a;
        obi_data_req_t d;
        reset        = 1'b1;
        instr_req    = 1'b0;
        instr_reqpar = 1'b1;
        instr_pl     = '0;
        data_req     = 1'b0;
        data_reqpar  = 1'b1;
        data_pl      = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        a_idle: assert (!instr_gnt && !data_gnt && !instr_rvalid && !data_rvalid &&
                        !vp.stdout_valid && !vp.exit_valid && alert == 2'b00)
            else fail_run("outputs not idle after reset");

        // Back-to-back random writes
        for (int n = 0; n < 24; n++) begin
            d = make_data(random_addr(), 1'b1, random_be(), $random(seed));
            drive_cycle(1'b0, make_fetch('0), 1'b1, d, 2'b00);
        end
        // Fetch alongside the write, then both ports read the same word
        for (int n = 0; n < 8; n++) begin
            a = random_addr();
            d = make_data(a, 1'b1, random_be(), $random(seed));
            drive_cycle(1'b1, make_fetch(a), 1'b1, d, 2'b00);
            drive_cycle(1'b1, make_fetch(a), 1'b1, make_data(a, 1'b0, 4'hf, '0), 2'b00);
        end
        for (int w = 0; w < 16; w++) begin
            d = make_data(32'((15 - w) * 4), 1'b0, 4'hf, '0);
            drive_cycle(1'b1, make_fetch(32'(w * 4)), 1'b1, d, 2'b00);
        end
        drain_responses();

        // Unmapped, window hole and top RAM word
        drive_cycle(1'b0, make_fetch('0), 1'b1, make_data(32'h2000_0000, 1'b0, 4'hf, '0), 2'b00);
        drive_cycle(1'b0, make_fetch('0), 1'b1,
                    make_data(`VP_BASE + 32'h8, 1'b1, 4'hf, 32'h55), 2'b00);
        drive_cycle(1'b0, make_fetch('0), 1'b1, make_data(32'h0000_0ffc, 1'b0, 4'hf, '0), 2'b00);
        drain_responses();

        // Characters with random lanes, then the exit code
        for (int n = 0; n < 3; n++) begin
            d = make_data(`VP_STDOUT_ADDR, 1'b1, random_be(), $random(seed));
            drive_cycle(1'b0, make_fetch('0), 1'b1, d, 2'b00);
        end
        drive_cycle(1'b0, make_fetch('0), 1'b1,
                    make_data(`VP_EXIT_ADDR, 1'b1, 4'hf, 32'h0000_002a), 2'b00);
        drain_responses();
        wait_exit();
        drive_cycle(1'b0, make_fetch('0), 1'b1, make_data(`VP_EXIT_ADDR, 1'b0, 4'hf, '0), 2'b00);
        drive_cycle(1'b0, make_fetch('0), 1'b1,
                    make_data(`VP_STDOUT_ADDR, 1'b0, 4'hf, '0), 2'b00);
        drain_responses();

        // Parity fault on the fetch port only
        drive_cycle(1'b0, make_fetch('0), 1'b0, make_data('0, 1'b0, 4'h0, '0), 2'b01);
        drain_responses();
        wait_alert(0);
        repeat (4) begin
            drain_responses();
        end

        // Data request with reqpar equal to req sets the data alert too
        drive_cycle(1'b0, make_fetch('0), 1'b1, make_data('0, 1'b0, 4'hf, '0), 2'b10);
        drain_responses();
        wait_alert(1);
        drain_responses();

        $display("No errors");
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/obi_mem_pkg.sv
source/obi_port_ctrl.sv
source/obi_ram.sv
source/obi_data_router.sv
source/vp_status.sv
source/obi_mem_wrap.sv
tests/tb_obi_mem_wrap.sv
